// File: hdl/z80_exec_pkg.sv
/* Shared types for the Z80 subset execute unit.
   Register code 6 means a memory operand, which this unit does not support. */
package z80_exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Z80 encoding: 0 B, 1 C, 2 D, 3 E, 4 H, 5 L, 6 (HL), 7 A
    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t REG_MEM = 3'd6;
    localparam reg_idx_t REG_A   = 3'd7;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode byte, two views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main table: group, destination or ALU op, source
    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
    } main_fields_t;

    // CB table: group, rotate kind or bit number, target
    typedef struct packed {
        logic [1:0] grp;
        logic [2:0] sel;
        logic [2:0] target;
    } cb_fields_t;

    typedef union packed {
        main_fields_t main;
        cb_fields_t   cb;
        logic [7:0]   raw;
    } opcode_u;

    // Incoming command, 17 bits
    typedef struct packed {
        logic       prefix_cb;
        opcode_u    op;
        logic [7:0] imm;
    } cmd_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded operation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        LOAD  = 3'd0,
        ALU   = 3'd1,
        ROT   = 3'd2,
        BIT   = 3'd3,
        UNSUP = 3'd4
    } op_kind_e;

    // ALU operation codes, same as opcode bits 5:3
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_ADC = 3'd1;
    localparam logic [2:0] ALU_SUB = 3'd2;
    localparam logic [2:0] ALU_SBC = 3'd3;
    localparam logic [2:0] ALU_AND = 3'd4;
    localparam logic [2:0] ALU_XOR = 3'd5;
    localparam logic [2:0] ALU_OR  = 3'd6;
    localparam logic [2:0] ALU_CP  = 3'd7;

    // Rotate and shift kinds, CB opcode bits 5:3
    localparam logic [2:0] ROT_RLC = 3'd0;
    localparam logic [2:0] ROT_RRC = 3'd1;
    localparam logic [2:0] ROT_RL  = 3'd2;
    localparam logic [2:0] ROT_RR  = 3'd3;
    localparam logic [2:0] ROT_SLA = 3'd4;
    localparam logic [2:0] ROT_SRA = 3'd5;
    localparam logic [2:0] ROT_SLL = 3'd6;
    localparam logic [2:0] ROT_SRL = 3'd7;

    // sub holds ALU op, rotate kind or bit number depending on kind
    typedef struct packed {
        op_kind_e   kind;
        logic [2:0] sub;
        reg_idx_t   src;
        reg_idx_t   dst;
        logic       use_imm;
        logic [7:0] imm;
    } dec_op_t;

    // Result record returned per command, 21 bits
    typedef struct packed {
        logic       unsup;
        logic       wr_en;
        reg_idx_t   dst;
        logic [7:0] value;
        logic [7:0] flags;
    } res_t;

    // Flag bit positions inside F
    localparam int FLAG_S  = 7;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_Y  = 5;
    localparam int FLAG_H  = 4;
    localparam int FLAG_X  = 3;
    localparam int FLAG_PV = 2;
    localparam int FLAG_N  = 1;
    localparam int FLAG_C  = 0;

endpackage

// File: hdl/op_decode.sv
/* Decode stage, one entry deep. Any form that names register code 6 is
   returned as unsupported, except the immediate LD r,n and ALU A,n forms. */
module op_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  z80_exec_pkg::cmd_t    cmd,
    output logic                  cmd_ready,
    output logic                  dec_valid,
    output z80_exec_pkg::dec_op_t dec,
    input  logic                  dec_ready
);
    import z80_exec_pkg::*;

    dec_op_t dec_next;
    logic    accept;

    // Ready when empty or when the held entry leaves this cycle
    assign cmd_ready = !dec_valid || dec_ready;
    assign accept    = cmd_valid && cmd_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        dec_next      = '0;
        dec_next.kind = UNSUP;
        dec_next.imm  = cmd.imm;
        if (cmd.prefix_cb) begin
            // CB table, only rotates and BIT on a real register
            if (cmd.op.cb.target != REG_MEM) begin
                dec_next.sub = cmd.op.cb.sel;
                dec_next.src = cmd.op.cb.target;
                dec_next.dst = cmd.op.cb.target;
                case (cmd.op.cb.grp)
                    2'b00:   dec_next.kind = ROT;
                    2'b01:   dec_next.kind = BIT;
                    // RES and SET are left out
                    default: dec_next.kind = UNSUP;
                endcase
            end
        end else begin
            case (cmd.op.main.x)
                2'b00: begin
                    // LD r,n sits at z == 6 in group 0
                    if (cmd.op.main.z == 3'd6 && cmd.op.main.y != REG_MEM) begin
                        dec_next.kind    = LOAD;
                        dec_next.dst     = cmd.op.main.y;
                        dec_next.use_imm = 1'b1;
                    end
                end
                2'b01: begin
                    // LD r,r' also excludes HALT (0x76)
                    if (cmd.op.main.y != REG_MEM && cmd.op.main.z != REG_MEM) begin
                        dec_next.kind = LOAD;
                        dec_next.dst  = cmd.op.main.y;
                        dec_next.src  = cmd.op.main.z;
                    end
                end
                2'b10: begin
                    // ALU A,r
                    if (cmd.op.main.z != REG_MEM) begin
                        dec_next.kind = ALU;
                        dec_next.sub  = cmd.op.main.y;
                        dec_next.src  = cmd.op.main.z;
                        dec_next.dst  = REG_A;
                    end
                end
                default: begin
                    // ALU A,n is z == 6 in group 3
                    // Rest of group 3 is not supported
                    if (cmd.op.main.z == 3'd6) begin
                        dec_next.kind    = ALU;
                        dec_next.sub     = cmd.op.main.y;
                        dec_next.dst     = REG_A;
                        dec_next.use_imm = 1'b1;
                    end
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (cmd_ready) begin
            dec_valid <= cmd_valid;
        end
    end

    // Payload loads only on a transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            dec <= dec_next;
        end
    end

    // Source must hold the command while it waits for ready
    a_cmd_hold: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("command changed before it was accepted");

endmodule

// File: hdl/reg_file.sv
/* Registers B, C, D, E, H, L, A and F with combinational reads.
   Code 6 holds no register and always reads as zero. */
module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  z80_exec_pkg::reg_idx_t rd_a_idx,
    input  z80_exec_pkg::reg_idx_t rd_b_idx,
    output logic [7:0]             rd_a,
    output logic [7:0]             rd_b,
    output logic [7:0]             flags_q,
    input  logic                   wr_en,
    input  z80_exec_pkg::reg_idx_t wr_idx,
    input  logic [7:0]             wr_data,
    input  logic                   flags_wr_en,
    input  logic [7:0]             flags_wr_data
);
    import z80_exec_pkg::*;

    // Indexed by Z80 register code, entry 6 unused
    logic [7:0] regs [8];
    logic [7:0] f_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 8'h00;
            end
            f_q <= 8'h00;
        end else begin
            // Entry 6 is never written so it stays zero
            if (wr_en && wr_idx != REG_MEM) begin
                regs[wr_idx] <= wr_data;
            end
            // F may be updated in the same cycle as a register
            if (flags_wr_en) begin
                f_q <= flags_wr_data;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port A normally points at the accumulator
    assign rd_a    = regs[rd_a_idx];
    // Port B serves the source or CB target
    assign rd_b    = regs[rd_b_idx];
    assign flags_q = f_q;

    // Decode must have filtered every memory form before execute
    a_no_mem_write: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> wr_idx != REG_MEM)
        else $error("register write to code 6");

endmodule

// File: hdl/alu_core.sv
/* Execute stage: operand read, 8-bit result, Z80 flags and write-back.
   Write-back lands on the edge that loads the result register, so the next
   operation always reads the updated state. */
module alu_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dec_valid,
    input  z80_exec_pkg::dec_op_t  dec,
    output logic                   dec_ready,
    output z80_exec_pkg::reg_idx_t rd_a_idx,
    output z80_exec_pkg::reg_idx_t rd_b_idx,
    input  logic [7:0]             rd_a,
    input  logic [7:0]             rd_b,
    input  logic [7:0]             flags_q,
    output logic                   wr_en,
    output z80_exec_pkg::reg_idx_t wr_idx,
    output logic [7:0]             wr_data,
    output logic                   flags_wr_en,
    output logic [7:0]             flags_wr_data,
    output logic                   res_valid,
    output z80_exec_pkg::res_t     res,
    input  logic                   res_ready
);
    import z80_exec_pkg::*;

    logic       accept;
    logic [7:0] operand;
    logic       carry_in;
    logic       sub_op;
    logic       logic_op;
    logic       use_cin;
    logic [7:0] b_inv;
    logic       cin;
    logic [8:0] sum9;
    logic [4:0] sum5;
    logic       arith_c;
    logic       arith_h;
    logic       arith_v;
    logic [7:0] rot_res;
    logic       rot_cout;
    logic       bit_val;
    logic [7:0] flags_n;
    logic       upd_flags;
    res_t       res_next;

    assign dec_ready = !res_valid || res_ready;
    assign accept    = dec_valid && dec_ready;

    // Port A fixed on A, port B follows the decoded source
    assign rd_a_idx = REG_A;
    assign rd_b_idx = dec.src;
    assign operand  = dec.use_imm ? dec.imm : rd_b;
    assign carry_in = flags_q[FLAG_C];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Adder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        sub_op   = (dec.sub == ALU_SUB) || (dec.sub == ALU_SBC) || (dec.sub == ALU_CP);
        logic_op = (dec.sub == ALU_AND) || (dec.sub == ALU_XOR) || (dec.sub == ALU_OR);
        use_cin  = (dec.sub == ALU_ADC) || (dec.sub == ALU_SBC);
        // Subtract as A + ~B + 1 - carry
        b_inv    = sub_op ? ~operand : operand;
        cin      = sub_op ? ~(use_cin & carry_in) : (use_cin & carry_in);
        sum9     = {1'b0, rd_a} + {1'b0, b_inv} + {8'd0, cin};
        sum5     = {1'b0, rd_a[3:0]} + {1'b0, b_inv[3:0]} + {4'd0, cin};
        // Borrow is the inverted carry out
        arith_c  = sum9[8] ^ sub_op;
        arith_h  = sum5[4] ^ sub_op;
        // Same sign in, different sign out
        arith_v  = (rd_a[7] == b_inv[7]) && (sum9[7] != rd_a[7]);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Rotates, shifts, bit test
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (dec.sub)
            ROT_RLC: rot_res = {rd_b[6:0], rd_b[7]};
            ROT_RRC: rot_res = {rd_b[0], rd_b[7:1]};
            ROT_RL:  rot_res = {rd_b[6:0], carry_in};
            ROT_RR:  rot_res = {carry_in, rd_b[7:1]};
            ROT_SLA: rot_res = {rd_b[6:0], 1'b0};
            ROT_SRA: rot_res = {rd_b[7], rd_b[7:1]};
            // Undocumented shift that fills with 1
            ROT_SLL: rot_res = {rd_b[6:0], 1'b1};
            ROT_SRL: rot_res = {1'b0, rd_b[7:1]};
            default: rot_res = rd_b;
        endcase
        // Odd kinds shift right
        rot_cout = dec.sub[0] ? rd_b[0] : rd_b[7];
        bit_val  = rd_b[dec.sub];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result record and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        res_next  = '0;
        flags_n   = flags_q;
        upd_flags = 1'b0;
        case (dec.kind)
            LOAD: begin
                // F untouched
                res_next.wr_en = 1'b1;
                res_next.dst   = dec.dst;
                res_next.value = operand;
            end
            ALU: begin
                upd_flags      = 1'b1;
                res_next.dst   = REG_A;
                // CP reports the difference but keeps A
                res_next.wr_en = (dec.sub != ALU_CP);
                case (dec.sub)
                    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP: res_next.value = sum9[7:0];
                    ALU_AND: res_next.value = rd_a & operand;
                    ALU_XOR: res_next.value = rd_a ^ operand;
                    ALU_OR:  res_next.value = rd_a | operand;
                    default: res_next.value = sum9[7:0];
                endcase
                flags_n[FLAG_S]  = res_next.value[7];
                flags_n[FLAG_Z]  = (res_next.value == 8'h00);
                // CP takes Y and X from the operand
                flags_n[FLAG_Y]  = (dec.sub == ALU_CP) ? operand[5] : res_next.value[5];
                flags_n[FLAG_X]  = (dec.sub == ALU_CP) ? operand[3] : res_next.value[3];
                flags_n[FLAG_H]  = logic_op ? (dec.sub == ALU_AND) : arith_h;
                flags_n[FLAG_PV] = logic_op ? ~^res_next.value : arith_v;
                flags_n[FLAG_N]  = sub_op;
                flags_n[FLAG_C]  = logic_op ? 1'b0 : arith_c;
            end
            ROT: begin
                upd_flags      = 1'b1;
                res_next.wr_en = 1'b1;
                res_next.dst   = dec.dst;
                res_next.value = rot_res;
                flags_n        = {rot_res[7], (rot_res == 8'h00), rot_res[5], 1'b0,
                                  rot_res[3], ~^rot_res, 1'b0, rot_cout};
            end
            BIT: begin
                // No register write
                // Value shows the tested register
                upd_flags        = 1'b1;
                res_next.dst     = dec.dst;
                res_next.value   = rd_b;
                flags_n[FLAG_S]  = (dec.sub == 3'd7) && bit_val;
                flags_n[FLAG_Z]  = ~bit_val;
                flags_n[FLAG_Y]  = rd_b[5];
                flags_n[FLAG_H]  = 1'b1;
                flags_n[FLAG_X]  = rd_b[3];
                flags_n[FLAG_PV] = ~bit_val;
                flags_n[FLAG_N]  = 1'b0;
            end
            default: begin
                // Unsupported op echoes F and changes no state
                res_next.unsup = 1'b1;
            end
        endcase
        res_next.flags = flags_n;
    end

    // Strobes only while the stage accepts
    assign wr_en         = accept && res_next.wr_en;
    assign wr_idx        = res_next.dst;
    assign wr_data       = res_next.value;
    assign flags_wr_en   = accept && upd_flags;
    assign flags_wr_data = flags_n;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (dec_ready) begin
            res_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res <= res_next;
        end
    end

    // Operands are read from dec, so it must hold while this stage stalls
    a_dec_hold: assert property (@(posedge clk) disable iff (reset)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec))
        else $error("decoded operation changed under back-pressure");

endmodule

// File: hdl/z80_exec_top.sv
/* Z80 subset execute unit, two pipeline stages with valid/ready streams.
   No memory operands, index registers or 16-bit operations. */
module z80_exec_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_valid,
    input  z80_exec_pkg::cmd_t cmd,
    output logic               cmd_ready,
    output logic               res_valid,
    output z80_exec_pkg::res_t res,
    input  logic               res_ready
);
    import z80_exec_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode to execute stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic    dec_valid;
    dec_op_t dec;
    logic    dec_ready;

    op_decode op_decode ( .* );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU and register file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side, combinational from reg_file
    reg_idx_t   rd_a_idx;
    reg_idx_t   rd_b_idx;
    logic [7:0] rd_a;
    logic [7:0] rd_b;
    logic [7:0] flags_q;

    // Write-back side
    logic       wr_en;
    reg_idx_t   wr_idx;
    logic [7:0] wr_data;
    logic       flags_wr_en;
    logic [7:0] flags_wr_data;

    alu_core alu_core ( .* );
    reg_file reg_file ( .* );

endmodule

// File: dv/exec_checker.sv
/* Result stream checker. Expected records are queued by the driver in command
   order and compared on every res transfer. */
module exec_checker (
    input logic               clk,
    input logic               reset,
    input logic               res_valid,
    input z80_exec_pkg::res_t res,
    input logic               res_ready
);
    import z80_exec_pkg::*;

    res_t exp_q[$];
    int   test_no    = 0;
    int   pass_count = 0;
    int   err_count  = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Access from the driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic expect_result(input res_t r);
        exp_q.push_back(r);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // Non-value failures such as timeouts
    task automatic note_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        err_count++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare on each transfer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Values read here are the ones present before the edge
    always @(posedge clk) begin
        res_t exp_r;
        if (!reset && res_valid && res_ready) begin
            test_no++;
            if (exp_q.size() == 0) begin
                note_error("result arrived with no command outstanding");
            end else begin
                exp_r = exp_q.pop_front();
                if (res !== exp_r) begin
                    $display("[FAIL] %0t test %0d: got unsup %0b wr_en %0b dst %0d value %h flags %h",
                             $time, test_no, res.unsup, res.wr_en, res.dst, res.value,
                             res.flags);
                    $display("[FAIL] %0t test %0d: exp unsup %0b wr_en %0b dst %0d value %h flags %h",
                             $time, test_no, exp_r.unsup, exp_r.wr_en, exp_r.dst,
                             exp_r.value, exp_r.flags);
                    err_count++;
                end else begin
                    $display("[PASS] test %0d value %h flags %h", test_no, res.value,
                             res.flags);
                    pass_count++;
                end
            end
        end
    end

endmodule

// File: dv/tb_top.sv
/* Testbench for the Z80 subset execute unit.
   Commands and expected result records come from dv/exec_input.txt, one per line.
   The mode column selects how res_ready is driven while the line is sent. */
module tb_top;
    import z80_exec_pkg::*;

    localparam int WAIT_LIMIT  = 64;
    localparam int STALL_TICKS = 6;

    logic clk;
    logic reset;
    logic cmd_valid;
    cmd_t cmd;
    logic cmd_ready;
    logic res_valid;
    res_t res;
    logic res_ready;

    integer seed = 32'h184;
    integer fd;
    reg [8*128-1:0] line_buf;
    int   n_fields;
    int   ntests;
    int   prev_mode;
    int   mode, pcb, opc, imm, unsup, wren, dst, val, flg;
    cmd_t c_next;
    res_t e_next;

    z80_exec_top uut (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    exec_checker chk (
        .clk       (clk),
        .reset     (reset),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    // 8 unit clock period
    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Driver helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Mode 0 random (about 70% high), 1 held low, 2 held high
    function automatic logic pick_ready(input int m);
        if (m == 1) begin
            return 1'b0;
        end
        if (m == 2) begin
            return 1'b1;
        end
        return ((($random(seed)) & 32'h7fff_ffff) % 10) < 7;
    endfunction

    // Inputs change 1 unit after the rising edge
    task automatic next_cycle(input int m);
        @(posedge clk);
        #1;
        res_ready = pick_ready(m);
    endtask

    // Entered at edge+1, returns at edge+1 after the transfer edge
    task automatic send_cmd(input cmd_t c, input res_t e, input int m);
        int waited;
        waited = 0;
        chk.expect_result(e);
        cmd       = c;
        cmd_valid = 1'b1;
        #1;
        while (!cmd_ready && waited < WAIT_LIMIT) begin
            next_cycle(m);
            #1;
            waited++;
        end
        if (!cmd_ready) begin
            chk.note_error("cmd_ready never came back high");
        end
        next_cycle(m);
    endtask

    // Empty the pipeline with res_ready high
    task automatic drain();
        int waited;
        waited    = 0;
        cmd_valid = 1'b0;
        while (chk.pending() != 0 && waited < WAIT_LIMIT) begin
            next_cycle(2);
            waited++;
        end
        if (chk.pending() != 0) begin
            chk.note_error("results still missing after drain");
        end
    endtask

    // Pipeline is full, so cmd_ready must stay low while res_ready is low
    task automatic check_stall();
        cmd_valid = 1'b0;
        repeat (STALL_TICKS) begin
            next_cycle(1);
            #1;
            if (cmd_ready) begin
                chk.note_error("cmd_ready stayed high under back-pressure");
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        res_ready = 1'b0;
        ntests    = 0;
        prev_mode = 0;
        fd = $fopen("dv/exec_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the input file dv/exec_input.txt");
            $display("Errors found");
        end else begin
            repeat (8) @(posedge clk);
            #1;
            reset = 1'b0;
            next_cycle(0);
            while (!$feof(fd)) begin
                line_buf = '0;
                void'($fgets(line_buf, fd));
                n_fields = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h",
                                   mode, pcb, opc, imm, unsup, wren, dst, val, flg);
                // Comment and blank lines give fewer fields
                if (n_fields == 9) begin
                    if (mode == 1 && prev_mode != 1) begin
                        drain();
                        next_cycle(1);
                    end
                    if (mode != 1 && prev_mode == 1) begin
                        check_stall();
                        next_cycle(mode);
                    end
                    c_next.prefix_cb = pcb[0];
                    c_next.op.raw    = opc[7:0];
                    c_next.imm       = imm[7:0];
                    e_next.unsup     = unsup[0];
                    e_next.wr_en     = wren[0];
                    e_next.dst       = dst[2:0];
                    e_next.value     = val[7:0];
                    e_next.flags     = flg[7:0];
                    send_cmd(c_next, e_next, mode);
                    ntests++;
                    prev_mode = mode;
                end
            end
            $fclose(fd);
            drain();
            repeat (4) next_cycle(2);
            $display("tests %0d passed %0d errors %0d", ntests, chk.pass_count,
                     chk.err_count);
            if (chk.err_count == 0 && chk.pass_count == ntests) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
        end
        $finish;
    end

endmodule

// File: dv/exec_input.txt
# mode prefix_cb opcode imm | unsup wr_en dst value flags   (hex)
# mode 0 random res_ready, 1 res_ready low, 2 res_ready high
# loads
0 0 06 12 0 1 0 12 00
0 0 0E 34 0 1 1 34 00
0 0 16 56 0 1 2 56 00
0 0 1E 78 0 1 3 78 00
0 0 26 9A 0 1 4 9A 00
0 0 2E BC 0 1 5 BC 00
0 0 3E 0F 0 1 7 0F 00
0 0 47 00 0 1 0 0F 00
0 0 50 00 0 1 2 0F 00
0 0 6A 00 0 1 5 0F 00
# ALU operations
0 0 80 00 0 1 7 1E 18
0 0 C6 F0 0 1 7 0E 09
0 0 89 00 0 1 7 43 10
0 0 D6 44 0 1 7 FF BB
0 0 9B 00 0 1 7 86 82
0 0 C6 80 0 1 7 06 05
0 0 DE 06 0 1 7 FF BB
0 0 E6 0F 0 1 7 0F 1C
0 0 AF 00 0 1 7 00 44
0 0 B4 00 0 1 7 9A 8C
0 0 FE 9A 0 0 7 00 4A
0 0 B9 00 0 0 7 66 26
0 0 47 00 0 1 0 9A 26
# CB rotates, shifts and BIT
0 1 00 00 0 1 0 35 25
0 1 19 00 0 1 1 9A 8C
0 1 22 00 0 1 2 1E 0C
0 1 2C 00 0 1 4 CD 88
0 1 3F 00 0 1 7 4D 0C
0 1 33 00 0 1 3 F1 A0
0 1 15 00 0 1 5 1E 0C
0 1 08 00 0 1 0 9A 8D
0 1 78 00 0 0 0 9A 99
0 1 40 00 0 0 0 9A 5D
0 1 57 00 0 0 7 4D 19
# unsupported forms, then a read of B
0 0 46 00 1 0 0 00 19
0 1 80 00 1 0 0 00 19
0 0 00 00 1 0 0 00 19
0 0 86 00 1 0 0 00 19
0 0 48 00 0 1 1 9A 19
# back-pressure
1 0 16 55 0 1 2 55 19
1 0 82 00 0 1 7 A2 B4
# back-to-back dependent operations
2 0 3E 01 0 1 7 01 B4
2 0 87 00 0 1 7 02 00
2 0 D6 02 0 1 7 00 42
2 0 DE 01 0 1 7 FF BB
2 0 CE 00 0 1 7 00 51
2 0 47 00 0 1 0 00 51

// File: list.f
hdl/z80_exec_pkg.sv
hdl/op_decode.sv
hdl/reg_file.sv
hdl/alu_core.sv
hdl/z80_exec_top.sv
dv/exec_checker.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# Compile and run the Z80 execute unit testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_top_sim

verilator --binary --timing --assert -f list.f --top-module tb_top \
    -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
